//--- logic/xdma_macros.svh
`ifndef XDMA_MACROS_SVH
`define XDMA_MACROS_SVH

// ---------------------------------------------------------------------------
// Widths
// ---------------------------------------------------------------------------
// Full chip-to-chip address
`define XDMA_ADDR_W 48
// Upper address bits naming the chip
`define XDMA_CHIP_ID_W 16
// Narrow beat
`define XDMA_DATA_W 64
`define XDMA_ID_W 8
// Beat count of one request
`define XDMA_LEN_W 16

// ---------------------------------------------------------------------------
// Address map
// ---------------------------------------------------------------------------
// One cluster window, 1 MB
`define XDMA_CLUSTER_SPACE 48'h10_0000
`define XDMA_CLUSTER_ADDR_W 20
// Main memory bounds, lower 32 address bits only
`define XDMA_MAIN_MEM_BASE 48'h8000_0000
`define XDMA_MAIN_MEM_END 48'h1_0000_0000
// Mailbox window, 4 KB
`define XDMA_MMIO_WIN 4096
// Config window sits third from the region end
`define XDMA_CFG_WIN_IDX 2

// Request buffer entries
`define XDMA_FIFO_DEPTH 4

`endif

//--- logic/xdma_pkg.sv
`default_nettype none

`include "xdma_macros.svh"

package xdma_pkg;

  // Chip-to-chip address, chip id in the top bits
  typedef logic [`XDMA_ADDR_W-1:0] addr_t;

  // One config beat
  typedef logic [`XDMA_DATA_W-1:0] data_t;

  // DMA transfer id
  typedef logic [`XDMA_ID_W-1:0] id_t;

  // Beat count, header included
  typedef logic [`XDMA_LEN_W-1:0] len_t;

  // Framer position inside a frame set
  typedef enum logic {
    FRAMER_HEADER,
    FRAMER_BODY
  } framer_state_e;

  // Write issuer phases
  typedef enum logic [1:0] {
    ISSUE_IDLE,
    ISSUE_ADDR,
    ISSUE_DATA
  } issuer_state_e;

endpackage : xdma_pkg

`default_nettype wire

//--- logic/xdma_cfg_framer.sv
`default_nettype none

`include "xdma_macros.svh"

module xdma_cfg_framer
  import xdma_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  // Config beats from the local DMA engine
  input  wire data_t cfg_data_i,
  input  wire logic  cfg_valid_i,
  output logic       cfg_ready_o,
  // Header fields, only meaningful on a header beat
  input  wire id_t   cfg_dma_id_i,
  input  wire logic  cfg_dma_type_i,
  input  wire addr_t cfg_reader_addr_i,
  input  wire addr_t cfg_writer_addr_i,
  input  wire len_t  cfg_frame_len_i,
  // Request FIFO write side
  input  wire logic  full_i,
  output logic       push_o,
  output data_t      push_data_o,
  output logic       push_first_o,
  output id_t        push_id_o,
  output len_t       push_len_o,
  output addr_t      push_addr_o
);

  localparam int AddrW    = `XDMA_ADDR_W;
  localparam int LowW     = `XDMA_ADDR_W - `XDMA_CHIP_ID_W;
  localparam int ClusterW = `XDMA_CLUSTER_ADDR_W;

  localparam addr_t ClusterSpace = addr_t'(`XDMA_CLUSTER_SPACE);
  localparam addr_t MainMemBase  = addr_t'(`XDMA_MAIN_MEM_BASE);
  localparam addr_t MainMemEnd   = addr_t'(`XDMA_MAIN_MEM_END);
  // Config mailbox starts 12 KB below the region end
  localparam addr_t CfgOffset    = addr_t'((`XDMA_CFG_WIN_IDX + 1) * `XDMA_MMIO_WIN);

  framer_state_e state_q, state_d;
  // Beats accepted so far in the current frame set
  len_t          beat_cnt_q, beat_cnt_d;
  // Frame set length, captured from the header
  len_t          total_len_q, total_len_d;

  logic          accept;
  logic          is_header;
  logic          sel_is_main;
  addr_t         sel_addr;
  addr_t         region_end;
  addr_t         remote_addr;
  len_t          frame_len;

  // Beat moves straight into the FIFO
  assign cfg_ready_o = ~full_i;
  assign accept      = cfg_valid_i & ~full_i;
  assign is_header   = (state_q == FRAMER_HEADER);

  // ---------------------------------------------------------------------------
  // Remote mailbox address
  // ---------------------------------------------------------------------------
  always_comb begin
    // Read pulls from the reader side, write pushes to the writer side
    sel_addr    = cfg_dma_type_i ? cfg_writer_addr_i : cfg_reader_addr_i;
    sel_is_main = (sel_addr[LowW-1:0] >= MainMemBase[LowW-1:0]);
    if (sel_is_main) begin
      // Chip base plus the main memory end
      region_end = {sel_addr[AddrW-1:LowW], {LowW{1'b0}}} + MainMemEnd;
    end else begin
      // Top of the owning cluster window
      region_end = {sel_addr[AddrW-1:ClusterW], {ClusterW{1'b0}}} + ClusterSpace;
    end
    remote_addr = region_end - CfgOffset;
  end

  // Zero or one frames both mean a lone header
  assign frame_len = (cfg_frame_len_i == '0) ? len_t'(1) : cfg_frame_len_i;

  // ---------------------------------------------------------------------------
  // FIFO push
  // ---------------------------------------------------------------------------
  assign push_o       = accept;
  assign push_data_o  = cfg_data_i;
  assign push_first_o = is_header;
  // Descriptor only rides on the header entry
  assign push_id_o    = is_header ? cfg_dma_id_i : '0;
  assign push_len_o   = is_header ? frame_len : '0;
  assign push_addr_o  = is_header ? remote_addr : '0;

  // ---------------------------------------------------------------------------
  // Header / body tracking
  // ---------------------------------------------------------------------------
  always_comb begin
    state_d     = state_q;
    beat_cnt_d  = beat_cnt_q;
    total_len_d = total_len_q;
    case (state_q)
      FRAMER_HEADER: begin
        // Body beats follow only for multi-frame sets
        if (accept && (frame_len > len_t'(1))) begin
          beat_cnt_d  = len_t'(1);
          total_len_d = frame_len;
          state_d     = FRAMER_BODY;
        end
      end
      FRAMER_BODY: begin
        if (accept) begin
          beat_cnt_d = beat_cnt_q + len_t'(1);
          // Next beat after the last body beat is a new header
          if (beat_cnt_q == total_len_q - len_t'(1)) begin
            beat_cnt_d = '0;
            state_d    = FRAMER_HEADER;
          end
        end
      end
      default: begin
        state_d = FRAMER_HEADER;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FRAMER_HEADER;
      beat_cnt_q  <= '0;
      total_len_q <= '0;
    end else begin
      state_q     <= state_d;
      beat_cnt_q  <= beat_cnt_d;
      total_len_q <= total_len_d;
    end
  end

  // A stalled beat holds its valid and data until accepted
  a_cfg_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cfg_valid_i && !cfg_ready_o) |=> (cfg_valid_i && $stable(cfg_data_i)))
    else $error("config beat dropped or changed while stalled");

endmodule : xdma_cfg_framer

`default_nettype wire

//--- logic/xdma_req_fifo.sv
`default_nettype none

`include "xdma_macros.svh"

module xdma_req_fifo
  import xdma_pkg::*;
#(
  parameter int unsigned DEPTH = `XDMA_FIFO_DEPTH
) (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  // Write side
  input  wire logic  push_i,
  input  wire data_t push_data_i,
  input  wire logic  push_first_i,
  input  wire id_t   push_id_i,
  input  wire len_t  push_len_i,
  input  wire addr_t push_addr_i,
  output logic       full_o,
  output logic       empty_o,
  // Read side
  input  wire logic  pop_i,
  output data_t      head_data_o,
  output logic       head_first_o,
  output id_t        head_id_o,
  output len_t       head_len_o,
  output addr_t      head_addr_o
);

  localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CntW = $clog2(DEPTH + 1);

  // Entry storage
  data_t           data_mem  [DEPTH];
  logic            first_mem [DEPTH];
  id_t             id_mem    [DEPTH];
  len_t            len_mem   [DEPTH];
  addr_t           addr_mem  [DEPTH];

  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;

  // Pointer step with wrap, also for non power-of-two depths
  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CntW'(DEPTH));
  assign empty_o = (count_q == '0);

  // Head entry straight from storage
  assign head_data_o  = data_mem[rd_ptr_q];
  assign head_first_o = first_mem[rd_ptr_q];
  assign head_id_o    = id_mem[rd_ptr_q];
  assign head_len_o   = len_mem[rd_ptr_q];
  assign head_addr_o  = addr_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      data_mem[wr_ptr_q]  <= push_data_i;
      first_mem[wr_ptr_q] <= push_first_i;
      id_mem[wr_ptr_q]    <= push_id_i;
      len_mem[wr_ptr_q]   <= push_len_i;
      addr_mem[wr_ptr_q]  <= push_addr_i;
    end
  end

  // ---------------------------------------------------------------------------
  // Pointers and occupancy
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // Simultaneous push and pop leave the count alone
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Framer must respect full
  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o)
    else $error("push into full request FIFO");

  // Issuer must respect empty
  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o)
    else $error("pop from empty request FIFO");

endmodule : xdma_req_fifo

`default_nettype wire

//--- logic/xdma_write_issuer.sv
`default_nettype none

module xdma_write_issuer
  import xdma_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  // Request FIFO head
  input  wire logic  empty_i,
  input  wire data_t head_data_i,
  input  wire logic  head_first_i,
  input  wire id_t   head_id_i,
  input  wire len_t  head_len_i,
  input  wire addr_t head_addr_i,
  output logic       pop_o,
  // Write address channel
  output logic       aw_valid_o,
  input  wire logic  aw_ready_i,
  output addr_t      aw_addr_o,
  output id_t        aw_id_o,
  output len_t       aw_len_o,
  // Write data channel
  output logic       w_valid_o,
  input  wire logic  w_ready_i,
  output data_t      w_data_o,
  output logic       w_last_o,
  // Completion
  output logic       done_o,
  output id_t        done_id_o
);

  issuer_state_e state_q, state_d;

  // Descriptor of the request in flight
  addr_t         addr_q;
  id_t           id_q;
  len_t          len_q;
  // W beats sent for the current request
  len_t          beat_cnt_q;

  logic          take_hdr;
  logic          aw_hs;
  logic          w_hs;
  logic          last_beat;
  logic          done_q;
  id_t           done_id_q;

  // Header waiting at the head while idle
  assign take_hdr  = (state_q == ISSUE_IDLE) & ~empty_i & head_first_i;

  // ---------------------------------------------------------------------------
  // Channel outputs
  // ---------------------------------------------------------------------------
  // Address payload held in registers, stable while stalled
  assign aw_valid_o = (state_q == ISSUE_ADDR);
  assign aw_addr_o  = addr_q;
  assign aw_id_o    = id_q;
  assign aw_len_o   = len_q;
  assign aw_hs      = aw_valid_o & aw_ready_i;

  // Head stays put until popped, so W payload is stable too
  assign w_valid_o  = (state_q == ISSUE_DATA) & ~empty_i;
  assign w_data_o   = head_data_i;
  assign last_beat  = (beat_cnt_q == len_q - len_t'(1));
  assign w_last_o   = (state_q == ISSUE_DATA) & last_beat;
  assign w_hs       = w_valid_o & w_ready_i;

  // One entry leaves per W beat
  assign pop_o      = w_hs;

  assign done_o     = done_q;
  assign done_id_o  = done_id_q;

  // ---------------------------------------------------------------------------
  // FSM
  // ---------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ISSUE_IDLE: begin
        if (take_hdr) begin
          state_d = ISSUE_ADDR;
        end
      end
      ISSUE_ADDR: begin
        if (aw_hs) begin
          state_d = ISSUE_DATA;
        end
      end
      ISSUE_DATA: begin
        if (w_hs && last_beat) begin
          state_d = ISSUE_IDLE;
        end
      end
      default: begin
        state_d = ISSUE_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ISSUE_IDLE;
      beat_cnt_q <= '0;
      done_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      // Restart the count for each address phase
      if (aw_hs) begin
        beat_cnt_q <= '0;
      end else if (w_hs) begin
        beat_cnt_q <= beat_cnt_q + len_t'(1);
      end
      // Pulse one cycle after the last W handshake
      done_q <= w_hs & last_beat;
    end
  end

  // Descriptor and completion id
  always_ff @(posedge clk_i) begin
    if (take_hdr) begin
      addr_q <= head_addr_i;
      id_q   <= head_id_i;
      len_q  <= head_len_i;
    end
    if (w_hs && last_beat) begin
      done_id_q <= id_q;
    end
  end

  // Stalled address phase keeps its payload
  a_aw_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (aw_valid_o && !aw_ready_i) |=>
      (aw_valid_o && $stable(aw_addr_o) && $stable(aw_id_o) && $stable(aw_len_o)))
    else $error("AW payload changed while stalled");

  // Framer and FIFO never slip a header into a running request
  a_no_mid_header : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((state_q == ISSUE_DATA) && !empty_i && (beat_cnt_q != '0)) |-> !head_first_i)
    else $error("header entry inside a request");

endmodule : xdma_write_issuer

`default_nettype wire

//--- logic/xdma_cfg_sender_top.sv
`default_nettype none

`include "xdma_macros.svh"

module xdma_cfg_sender_top
  import xdma_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  // Config beats and header fields
  input  wire data_t cfg_data_i,
  input  wire logic  cfg_valid_i,
  output logic       cfg_ready_o,
  input  wire id_t   cfg_dma_id_i,
  input  wire logic  cfg_dma_type_i,
  input  wire addr_t cfg_reader_addr_i,
  input  wire addr_t cfg_writer_addr_i,
  input  wire len_t  cfg_frame_len_i,
  // Write address channel
  output logic       aw_valid_o,
  input  wire logic  aw_ready_i,
  output addr_t      aw_addr_o,
  output id_t        aw_id_o,
  output len_t       aw_len_o,
  // Write data channel
  output logic       w_valid_o,
  input  wire logic  w_ready_i,
  output data_t      w_data_o,
  output logic       w_last_o,
  // Completion
  output logic       done_o,
  output id_t        done_id_o
);

  // Framer to FIFO
  logic  push;
  data_t push_data;
  logic  push_first;
  id_t   push_id;
  len_t  push_len;
  addr_t push_addr;
  logic  full;

  // FIFO to issuer
  logic  empty;
  logic  pop;
  data_t head_data;
  logic  head_first;
  id_t   head_id;
  len_t  head_len;
  addr_t head_addr;

  xdma_cfg_framer i_framer (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .cfg_data_i        (cfg_data_i),
    .cfg_valid_i       (cfg_valid_i),
    .cfg_ready_o       (cfg_ready_o),
    .cfg_dma_id_i      (cfg_dma_id_i),
    .cfg_dma_type_i    (cfg_dma_type_i),
    .cfg_reader_addr_i (cfg_reader_addr_i),
    .cfg_writer_addr_i (cfg_writer_addr_i),
    .cfg_frame_len_i   (cfg_frame_len_i),
    .full_i            (full),
    .push_o            (push),
    .push_data_o       (push_data),
    .push_first_o      (push_first),
    .push_id_o         (push_id),
    .push_len_o        (push_len),
    .push_addr_o       (push_addr)
  );

  xdma_req_fifo #(
    .DEPTH (`XDMA_FIFO_DEPTH)
  ) i_req_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (push),
    .push_data_i  (push_data),
    .push_first_i (push_first),
    .push_id_i    (push_id),
    .push_len_i   (push_len),
    .push_addr_i  (push_addr),
    .full_o       (full),
    .empty_o      (empty),
    .pop_i        (pop),
    .head_data_o  (head_data),
    .head_first_o (head_first),
    .head_id_o    (head_id),
    .head_len_o   (head_len),
    .head_addr_o  (head_addr)
  );

  xdma_write_issuer i_issuer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .empty_i      (empty),
    .head_data_i  (head_data),
    .head_first_i (head_first),
    .head_id_i    (head_id),
    .head_len_i   (head_len),
    .head_addr_i  (head_addr),
    .pop_o        (pop),
    .aw_valid_o   (aw_valid_o),
    .aw_ready_i   (aw_ready_i),
    .aw_addr_o    (aw_addr_o),
    .aw_id_o      (aw_id_o),
    .aw_len_o     (aw_len_o),
    .w_valid_o    (w_valid_o),
    .w_ready_i    (w_ready_i),
    .w_data_o     (w_data_o),
    .w_last_o     (w_last_o),
    .done_o       (done_o),
    .done_id_o    (done_id_o)
  );

endmodule : xdma_cfg_sender_top

`default_nettype wire

//--- sim/tb_xdma_cfg_sender.sv
`default_nettype none

`include "xdma_macros.svh"

module tb_xdma_cfg_sender
  import xdma_pkg::*;
();

  localparam int NUM_ROWS = 6;
  localparam int DEPTH    = `XDMA_FIFO_DEPTH;
  localparam int PERIOD   = 100;
  // Both ready lines held low this long so the FIFO fills
  localparam int STALL_CYCLES = 20;

  logic  clk_i;
  logic  rst_ni;
  data_t cfg_data_i;
  logic  cfg_valid_i;
  logic  cfg_ready_o;
  id_t   cfg_dma_id_i;
  logic  cfg_dma_type_i;
  addr_t cfg_reader_addr_i;
  addr_t cfg_writer_addr_i;
  len_t  cfg_frame_len_i;
  logic  aw_valid_o;
  logic  aw_ready_i;
  addr_t aw_addr_o;
  id_t   aw_id_o;
  len_t  aw_len_o;
  logic  w_valid_o;
  logic  w_ready_i;
  data_t w_data_o;
  logic  w_last_o;
  logic  done_o;
  id_t   done_id_o;

  // ---------------------------------------------------------------------------
  // Stimulus table of id, type, reader, writer, frame count and word base
  // ---------------------------------------------------------------------------
  id_t   tbl_id   [NUM_ROWS] = '{8'h11, 8'h22, 8'h33, 8'h44, 8'h55, 8'h66};
  // 0 read, 1 write
  logic  tbl_type [NUM_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
  addr_t tbl_rd   [NUM_ROWS] = '{48'h0001_0012_3456, 48'h0000_0004_0000,
                                 48'h0002_0007_FFF8, 48'h0004_9000_0000,
                                 48'h0002_FFFF_F000, 48'h0000_0000_0000};
  addr_t tbl_wr   [NUM_ROWS] = '{48'h0005_0000_0000, 48'h0003_8000_1000,
                                 48'h0000_0000_0000, 48'h0004_00A5_0000,
                                 48'h0000_0010_0000, 48'h0007_7FFF_FFFF};
  len_t  tbl_len  [NUM_ROWS] = '{16'd5, 16'd1, 16'd0, 16'd3, 16'd7, 16'd2};
  data_t tbl_base [NUM_ROWS] = '{64'hA000_0000_0000_0000, 64'hB100_0000_0000_0000,
                                 64'hC200_0000_0000_0000, 64'hD300_0000_0000_0000,
                                 64'hE400_0000_0000_0000, 64'hF500_0000_0000_0000};

  // Scoreboard
  addr_t exp_aw_addr [$];
  id_t   exp_aw_id   [$];
  len_t  exp_aw_len  [$];
  data_t exp_w_data  [$];
  logic  exp_w_last  [$];
  id_t   exp_done_id [$];

  int    errors;
  int    checks;
  int    occupancy;
  int    full_cycles;
  int    done_seen;
  logic  done_due;
  id_t   done_id_due;
  logic  aw_hs_prev;
  logic  in_request;

  xdma_cfg_sender_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic check_val(input string what, input logic [63:0] got,
                           input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // A lone header beat for a count of 0 or 1
  function automatic len_t frame_beats(input len_t n);
    return (n < 16'd2) ? 16'd1 : n;
  endfunction

  // Mailbox sits 12 KB below the end of the selected region
  function automatic addr_t mailbox_addr(input logic typ, input addr_t rd, input addr_t wr);
    addr_t sel;
    addr_t top;
    sel = typ ? wr : rd;
    if (sel[31:0] >= 32'h8000_0000) begin
      // Main memory ends 4 GB above the chip base
      top = {sel[47:32], 32'h0000_0000} + 48'h1_0000_0000;
    end else begin
      top = {sel[47:20], 20'h0_0000} + 48'h10_0000;
    end
    return top - 48'h3000;
  endfunction

  // ---------------------------------------------------------------------------
  // Drivers
  // ---------------------------------------------------------------------------
  task automatic drive_ready();
    int cyc;
    cyc = 0;
    forever begin
      @(negedge clk_i);
      if (cyc < STALL_CYCLES) begin
        aw_ready_i = 1'b0;
        w_ready_i  = 1'b0;
      end else begin
        // Ready about two cycles in three
        aw_ready_i = ($urandom_range(0, 2) != 0);
        w_ready_i  = ($urandom_range(0, 2) != 0);
      end
      cyc++;
    end
  endtask

  task automatic apply_row(input int r);
    int   k;
    int   gap;
    len_t beats;
    logic accepted;
    beats = frame_beats(tbl_len[r]);
    for (k = 0; k < beats; k++) begin
      gap = $urandom_range(0, 2);
      repeat (gap) @(negedge clk_i);
      cfg_valid_i = 1'b1;
      cfg_data_i  = tbl_base[r] + data_t'(k);
      if (k == 0) begin
        cfg_dma_id_i      = tbl_id[r];
        cfg_dma_type_i    = tbl_type[r];
        cfg_reader_addr_i = tbl_rd[r];
        cfg_writer_addr_i = tbl_wr[r];
        cfg_frame_len_i   = tbl_len[r];
      end else begin
        // Header fields are don't care on body beats
        cfg_dma_id_i      = id_t'($urandom);
        cfg_dma_type_i    = ($urandom_range(0, 1) != 0);
        cfg_reader_addr_i = addr_t'({$urandom, $urandom});
        cfg_writer_addr_i = addr_t'({$urandom, $urandom});
        cfg_frame_len_i   = len_t'($urandom);
      end
      accepted = 1'b0;
      while (!accepted) begin
        @(posedge clk_i);
        accepted = cfg_ready_o;
        @(negedge clk_i);
      end
      cfg_valid_i = 1'b0;
    end
  endtask

  // ---------------------------------------------------------------------------
  // Monitor sampling pre-edge values on each rising edge
  // ---------------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (rst_ni) begin
      check_val("done_o", done_o, done_due);
      if (done_o) begin
        done_seen++;
        if (done_due) check_val("done_id_o", done_id_o, done_id_due);
      end
      done_due = 1'b0;
      // Ready low exactly while the FIFO holds DEPTH entries
      check_val("cfg_ready_o", cfg_ready_o, occupancy != DEPTH);
      if (!cfg_ready_o) full_cycles++;
      if (cfg_valid_i && cfg_ready_o) occupancy++;
      if (w_valid_o && w_ready_i) occupancy--;
      // First W beat offered right after the AW handshake
      if (aw_hs_prev) check_val("w_valid_o after AW", w_valid_o, 1'b1);
      aw_hs_prev = aw_valid_o && aw_ready_i;
      if (aw_valid_o && aw_ready_i) begin
        if (exp_aw_addr.size() == 0) begin
          errors++;
          $display("Address phase at %0t with no request expected", $time);
        end else begin
          check_val("aw_addr_o", aw_addr_o, exp_aw_addr.pop_front());
          check_val("aw_id_o", aw_id_o, exp_aw_id.pop_front());
          check_val("aw_len_o", aw_len_o, exp_aw_len.pop_front());
        end
        in_request = 1'b1;
      end
      if (w_valid_o && w_ready_i) begin
        if (!in_request || exp_w_data.size() == 0) begin
          errors++;
          $display("Data beat at %0t outside of any request", $time);
        end else begin
          check_val("w_data_o", w_data_o, exp_w_data.pop_front());
          check_val("w_last_o", w_last_o, exp_w_last[0]);
          if (exp_w_last.pop_front()) begin
            done_due    = 1'b1;
            done_id_due = exp_done_id.pop_front();
            in_request  = 1'b0;
          end
        end
      end
    end
  end

  // Watchdog sized from the table
  initial begin
    int total;
    total = 0;
    for (int r = 0; r < NUM_ROWS; r++) total += frame_beats(tbl_len[r]);
    #((total * 40 + 200) * PERIOD);
    $display("Timeout: the DUT did not complete all requests in time");
    $display("Test failed");
    $finish;
  end

  initial begin
    len_t n;
    void'($urandom(22292));
    errors      = 0;
    checks      = 0;
    occupancy   = 0;
    full_cycles = 0;
    done_seen   = 0;
    done_due    = 1'b0;
    done_id_due = '0;
    aw_hs_prev  = 1'b0;
    in_request  = 1'b0;
    rst_ni            = 1'b0;
    cfg_data_i        = '0;
    cfg_valid_i       = 1'b0;
    cfg_dma_id_i      = '0;
    cfg_dma_type_i    = 1'b0;
    cfg_reader_addr_i = '0;
    cfg_writer_addr_i = '0;
    cfg_frame_len_i   = '0;
    aw_ready_i        = 1'b0;
    w_ready_i         = 1'b0;

    // Expected traffic from the address and length rules
    for (int r = 0; r < NUM_ROWS; r++) begin
      n = frame_beats(tbl_len[r]);
      exp_aw_addr.push_back(mailbox_addr(tbl_type[r], tbl_rd[r], tbl_wr[r]));
      exp_aw_id.push_back(tbl_id[r]);
      exp_aw_len.push_back(n);
      exp_done_id.push_back(tbl_id[r]);
      for (int k = 0; k < n; k++) begin
        exp_w_data.push_back(tbl_base[r] + data_t'(k));
        exp_w_last.push_back(k == n - 1);
      end
    end

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_val("aw_valid_o after reset", aw_valid_o, 1'b0);
    check_val("w_valid_o after reset", w_valid_o, 1'b0);
    check_val("done_o after reset", done_o, 1'b0);
    check_val("cfg_ready_o after reset", cfg_ready_o, 1'b1);

    fork
      drive_ready();
    join_none

    for (int r = 0; r < NUM_ROWS; r++) apply_row(r);
    wait (done_seen >= NUM_ROWS);
    repeat (4) @(negedge clk_i);

    check_val("requests completed", done_seen, NUM_ROWS);
    check_val("AW left unsent", exp_aw_addr.size(), 0);
    check_val("W left unsent", exp_w_data.size(), 0);
    if (full_cycles == 0) begin
      errors++;
      $display("The FIFO never filled, so cfg_ready_o was never seen low");
    end

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : tb_xdma_cfg_sender

`default_nettype wire

//--- build.f
+incdir+logic
logic/xdma_pkg.sv
logic/xdma_cfg_framer.sv
logic/xdma_req_fifo.sv
logic/xdma_write_issuer.sv
logic/xdma_cfg_sender_top.sv
sim/tb_xdma_cfg_sender.sv
